/* decode_issue.sv */
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module decode_issue import rv_decode_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  de_in_t      in,
    input  xlen_t       imm,
    input  xlen_t       rs1_val,
    input  xlen_t       rs2_val,
    input  logic        credit_return,
    output logic        in_ready,
    output logic        out_valid,
    output exe_bundle_t out
);

    logic        [6:0] opcode;
    logic              accept;
    credit_cnt_t       credits;
    exe_bundle_t       next_bundle;

    assign opcode = in.ir[6:0];

    //////////////////////////////
    // Flow control
    //////////////////////////////

    assign in_ready = (credits != '0);
    assign accept   = in_valid && in_ready;

    // One credit per issued bundle, one back per return pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= credit_cnt_t'(`DE_CREDITS);
        end else if (accept && !credit_return) begin
            credits <= credits - 1'b1;
        end else if (!accept && credit_return) begin
            credits <= credits + 1'b1;
        end
    end

    //////////////////////////////
    // Operand select
    //////////////////////////////

    always_comb begin
        next_bundle.pc      = in.pc;
        next_bundle.ir      = in.ir;
        next_bundle.rs2_val = rs2_val;
        next_bundle.imm     = imm;

        // Operand A
        case (opcode)
            `OP_AUIPC, `OP_JAL: next_bundle.op_a = in.pc;
            `OP_LUI:            next_bundle.op_a = '0;
            default:            next_bundle.op_a = rs1_val;
        endcase

        // Operand B, register for R-type and compares
        case (opcode)
            `OP_REG, `OP_REG32, `OP_BRANCH: next_bundle.op_b = rs2_val;
            default:                        next_bundle.op_b = imm;
        endcase

        next_bundle.is_branch = (opcode == `OP_BRANCH);
        // ECALL is the all-zero SYSTEM word
        next_bundle.is_ecall  = (in.ir == {25'd0, `OP_SYSTEM});
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out <= next_bundle;
        end
    end

endmodule

/* decode_top.f */
+incdir+.
rv_decode_pkg.sv
reg_file.sv
imm_gen.sv
operand_fwd.sv
decode_issue.sv
decode_top.sv
tb_decode_top.sv

/* decode_top.sv */
`timescale 1ns/1ps

module decode_top import rv_decode_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  de_in_t      in,
    output logic        in_ready,
    input  fwd_t        exe_fwd,
    input  fwd_t        mem_fwd,
    input  fwd_t        wb_fwd,
    input  logic        credit_return,
    output logic        out_valid,
    output exe_bundle_t out
);

    xlen_t imm;
    xlen_t rs1_val;
    xlen_t rs2_val;

    // Immediate and operand paths run in parallel
    imm_gen u_imm_gen (
        .ir  (in.ir),
        .imm (imm)
    );

    operand_fwd u_operand_fwd (
        .clk     (clk),
        .reset   (reset),
        .ir      (in.ir),
        .exe_fwd (exe_fwd),
        .mem_fwd (mem_fwd),
        .wb_fwd  (wb_fwd),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    //////////////////////////////
    // Issue to execute
    //////////////////////////////

    decode_issue u_decode_issue (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in            (in),
        .imm           (imm),
        .rs1_val       (rs1_val),
        .rs2_val       (rs2_val),
        .credit_return (credit_return),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .out           (out)
    );

endmodule

/* imm_gen.sv */
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module imm_gen import rv_decode_pkg::*; (
    input  inst_t ir,
    output xlen_t imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    xlen_t      i_imm;
    xlen_t      shamt6;
    xlen_t      shamt5;

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];

    // Shared I-type value, sign bit is always ir[31]
    assign i_imm = {{(`XLEN-12){ir[31]}}, ir[31:20]};

    // 64-bit shifts use six bits, word shifts five
    assign shamt6 = {{(`XLEN-6){1'b0}}, ir[25:20]};
    assign shamt5 = {{(`XLEN-5){1'b0}}, ir[24:20]};

    //////////////////////////////
    // Format select
    //////////////////////////////

    always_comb begin
        imm = '0;
        case (opcode)
            `OP_STORE: begin
                imm = {{(`XLEN-12){ir[31]}}, ir[31:25], ir[11:7]};
            end
            `OP_BRANCH: begin
                imm = {{(`XLEN-13){ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            end
            `OP_LUI, `OP_AUIPC: begin
                imm = {{(`XLEN-32){ir[31]}}, ir[31:12], 12'd0};
            end
            `OP_JAL: begin
                imm = {{(`XLEN-21){ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            end
            `OP_LOAD, `OP_JALR: begin
                imm = i_imm;
            end
            `OP_IMM: begin
                // SLLI, SRLI and SRAI
                if (funct3[1:0] == 2'b01) begin
                    imm = shamt6;
                end else begin
                    imm = i_imm;
                end
            end
            `OP_IMM32: begin
                if (funct3 == 3'b000) begin
                    imm = i_imm;
                end else if (funct3[1:0] == 2'b01) begin
                    imm = shamt5;
                end
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

/* operand_fwd.sv */
`timescale 1ns/1ps

module operand_fwd import rv_decode_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  inst_t ir,
    input  fwd_t  exe_fwd,
    input  fwd_t  mem_fwd,
    input  fwd_t  wb_fwd,
    output xlen_t rs1_val,
    output xlen_t rs2_val
);

    reg_id_t rs1_id;
    reg_id_t rs2_id;
    xlen_t   rf_rs1;
    xlen_t   rf_rs2;

    assign rs1_id = ir[19:15];
    assign rs2_id = ir[24:20];

    //////////////////////////////
    // Register file
    //////////////////////////////

    // Writeback stage result is also the write port
    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1_id   (rs1_id),
        .rs2_id   (rs2_id),
        .wr       (wb_fwd),
        .rs1_data (rf_rs1),
        .rs2_data (rf_rs2)
    );

    //////////////////////////////
    // Bypass select
    //////////////////////////////

    // Youngest producer wins
    function automatic xlen_t pick_src(
        input reg_id_t id,
        input xlen_t   rf_val,
        input fwd_t    exe,
        input fwd_t    mem,
        input fwd_t    wb
    );
        xlen_t val;
        if (id == '0) begin
            val = '0;
        end else if (exe.valid && (exe.rd == id)) begin
            val = exe.data;
        end else if (mem.valid && (mem.rd == id)) begin
            val = mem.data;
        end else if (wb.valid && (wb.rd == id)) begin
            val = wb.data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    always_comb begin
        rs1_val = pick_src(rs1_id, rf_rs1, exe_fwd, mem_fwd, wb_fwd);
        rs2_val = pick_src(rs2_id, rf_rs2, exe_fwd, mem_fwd, wb_fwd);
    end

endmodule

/* reg_file.sv */
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module reg_file import rv_decode_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  reg_id_t rs1_id,
    input  reg_id_t rs2_id,
    input  fwd_t    wr,
    output xlen_t   rs1_data,
    output xlen_t   rs2_data
);

    // x0 has no storage
    xlen_t regs [1:`NUM_REGS-1];

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && (wr.rd != '0)) begin
            regs[wr.rd] <= wr.data;
        end
    end

    //////////////////////////////
    // Read ports
    //////////////////////////////

    // Old value on a same-cycle write, bypass covers the new one
    always_comb begin
        rs1_data = '0;
        rs2_data = '0;
        if (rs1_id != '0) begin
            rs1_data = regs[rs1_id];
        end
        if (rs2_id != '0) begin
            rs2_data = regs[rs2_id];
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f decode_top.f --top-module tb_decode_top -Mdir obj_dir -o sim_decode
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_decode > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
exit 0

/* rv_decode_macros.svh */
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// Datapath sizing
`define XLEN       64
`define NUM_REGS   32
`define DE_CREDITS 4

// RV64I major opcodes
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_IMM    7'b0010011
`define OP_IMM32  7'b0011011
`define OP_REG    7'b0110011
`define OP_REG32  7'b0111011
`define OP_SYSTEM 7'b1110011

`endif

/* rv_decode_pkg.sv */
`include "rv_decode_macros.svh"

package rv_decode_pkg;

    //////////////////////////////
    // Scalar types
    //////////////////////////////

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_id_t;

    // Must be able to hold the full reset value
    typedef logic [$clog2(`DE_CREDITS+1)-1:0] credit_cnt_t;

    //////////////////////////////
    // Bundles
    //////////////////////////////

    // One bypass source, also used as the register file write port
    typedef struct packed {
        logic    valid;
        reg_id_t rd;
        xlen_t   data;
    } fwd_t;

    // Instruction arriving from fetch
    typedef struct packed {
        xlen_t pc;
        inst_t ir;
    } de_in_t;

    // Registered output to execute
    typedef struct packed {
        xlen_t pc;
        inst_t ir;
        xlen_t op_a;
        xlen_t op_b;
        xlen_t rs2_val;    // store data or branch compare value
        xlen_t imm;
        logic  is_branch;
        logic  is_ecall;
    } exe_bundle_t;

endpackage

/* tb_decode_top.sv */
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module tb_decode_top import rv_decode_pkg::*; ();

    localparam int NUM_INSTS   = 2000;
    // Ten cycles per instruction is far above the credit round trip
    localparam int CYCLE_LIMIT = NUM_INSTS * 10;

    logic        clk = 1'b0;
    logic        reset;
    logic        in_valid;
    de_in_t      in;
    logic        in_ready;
    fwd_t        exe_fwd;
    fwd_t        mem_fwd;
    fwd_t        wb_fwd;
    logic        credit_return;
    logic        out_valid;
    exe_bundle_t out;

    integer      seed;
    int          cycle;
    int          accepted;
    int          received;
    int          model_credits;
    int          value_errs;
    int          flow_errs;
    logic        hold_credits;
    logic        accepted_last;
    logic        timed_out;
    xlen_t       model_regs [0:`NUM_REGS-1];
    exe_bundle_t exp_q [$];
    int          ret_due [$];

    decode_top u_dut (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in            (in),
        .in_ready      (in_ready),
        .exe_fwd       (exe_fwd),
        .mem_fwd       (mem_fwd),
        .wb_fwd        (wb_fwd),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out           (out)
    );

    initial forever #5 clk = ~clk;

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    function automatic xlen_t random_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    // Mostly x0..x7 so bypass hits are common
    function automatic reg_id_t small_reg();
        logic [31:0] r;
        r = $random(seed);
        if (r[4:3] != 2'b00) return {2'b00, r[2:0]};
        return r[9:5];
    endfunction

    function automatic fwd_t random_fwd();
        fwd_t        f;
        logic [31:0] r;
        r       = $random(seed);
        f.valid = r[0];
        f.rd    = small_reg();
        f.data  = random_word();
        return f;
    endfunction

    function automatic inst_t random_inst();
        logic [31:0] r;
        inst_t       ir;
        r         = $random(seed);
        ir        = $random(seed);
        ir[11:7]  = small_reg();
        ir[19:15] = small_reg();
        ir[24:20] = small_reg();
        case (r[3:0])
            4'd0:               ir[6:0] = `OP_LUI;
            4'd1:               ir[6:0] = `OP_AUIPC;
            4'd2:               ir[6:0] = `OP_JAL;
            4'd3:               ir[6:0] = `OP_JALR;
            4'd4:               ir[6:0] = `OP_BRANCH;
            4'd5:               ir[6:0] = `OP_LOAD;
            4'd6:               ir[6:0] = `OP_STORE;
            4'd7, 4'd12, 4'd13: ir[6:0] = `OP_IMM;
            4'd8: begin
                // ADDIW, SLLIW or SRLIW/SRAIW
                ir[6:0]   = `OP_IMM32;
                ir[14:12] = r[4] ? 3'b000 : {r[5], 2'b01};
            end
            4'd9:               ir[6:0] = `OP_REG;
            4'd10:              ir[6:0] = `OP_REG32;
            4'd11:              ir[6:0] = `OP_SYSTEM;
            default:            ir = 32'h0000_0073;
        endcase
        return ir;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Arithmetic shift of a left-aligned field sign-extends it
    function automatic xlen_t sext_field(logic [63:0] aligned, int shift);
        logic signed [63:0] s;
        s = aligned;
        return s >>> shift;
    endfunction

    function automatic xlen_t expected_imm(inst_t ir);
        xlen_t i_fmt;
        i_fmt = sext_field({ir[31:20], 52'd0}, 52);
        case (ir[6:0])
            `OP_STORE:          return sext_field({ir[31:25], ir[11:7], 52'd0}, 52);
            `OP_BRANCH:         return sext_field({ir[31], ir[7], ir[30:25], ir[11:8], 52'd0}, 51);
            `OP_LUI, `OP_AUIPC: return sext_field({ir[31:12], 44'd0}, 32);
            `OP_JAL:            return sext_field({ir[31], ir[19:12], ir[20], ir[30:21], 44'd0}, 43);
            `OP_LOAD, `OP_JALR: return i_fmt;
            `OP_IMM:            return (ir[13:12] == 2'b01) ? {58'd0, ir[25:20]} : i_fmt;
            `OP_IMM32: begin
                if (ir[14:12] == 3'b000) return i_fmt;
                if (ir[13:12] == 2'b01) return {59'd0, ir[24:20]};
                return '0;
            end
            default:            return '0;
        endcase
    endfunction

    // Exe over mem over wb over the register file
    // x0 is never bypassed
    function automatic xlen_t read_operand(reg_id_t id, fwd_t e, fwd_t m, fwd_t w);
        if (id == '0) return '0;
        if (e.valid && e.rd == id) return e.data;
        if (m.valid && m.rd == id) return m.data;
        if (w.valid && w.rd == id) return w.data;
        return model_regs[id];
    endfunction

    function automatic exe_bundle_t decode_ref(de_in_t ins, fwd_t e, fwd_t m, fwd_t w);
        exe_bundle_t b;
        logic [6:0]  opc;
        opc         = ins.ir[6:0];
        b.pc        = ins.pc;
        b.ir        = ins.ir;
        b.rs2_val   = read_operand(ins.ir[24:20], e, m, w);
        b.imm       = expected_imm(ins.ir);
        b.op_a      = (opc == `OP_AUIPC || opc == `OP_JAL) ? ins.pc :
                      (opc == `OP_LUI) ? '0 : read_operand(ins.ir[19:15], e, m, w);
        b.op_b      = (opc == `OP_REG || opc == `OP_REG32 || opc == `OP_BRANCH) ? b.rs2_val : b.imm;
        b.is_branch = (opc == `OP_BRANCH);
        b.is_ecall  = (ins.ir == 32'h0000_0073);
        return b;
    endfunction

    //////////////////////////////
    // Checking
    //////////////////////////////

    task automatic value_error(string name, xlen_t exp_v, xlen_t got_v);
        $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp_v, got_v);
        value_errs++;
    endtask

    task automatic flow_error(string msg);
        $display("Flow error at %0t ns: %s", $time, msg);
        flow_errs++;
    endtask

    task automatic compare_bundle(exe_bundle_t got, exe_bundle_t exp_b);
        if (got.pc !== exp_b.pc) value_error("out.pc", exp_b.pc, got.pc);
        if (got.ir !== exp_b.ir) value_error("out.ir", xlen_t'(exp_b.ir), xlen_t'(got.ir));
        if (got.op_a !== exp_b.op_a) value_error("out.op_a", exp_b.op_a, got.op_a);
        if (got.op_b !== exp_b.op_b) value_error("out.op_b", exp_b.op_b, got.op_b);
        if (got.rs2_val !== exp_b.rs2_val) value_error("out.rs2_val", exp_b.rs2_val, got.rs2_val);
        if (got.imm !== exp_b.imm) value_error("out.imm", exp_b.imm, got.imm);
        if (got.is_branch !== exp_b.is_branch)
            value_error("out.is_branch", xlen_t'(exp_b.is_branch), xlen_t'(got.is_branch));
        if (got.is_ecall !== exp_b.is_ecall)
            value_error("out.is_ecall", xlen_t'(exp_b.is_ecall), xlen_t'(got.is_ecall));
    endtask

    // Driver that also keeps the register and credit models
    always @(posedge clk) begin
        de_in_t      nxt;
        logic        acc;
        logic [31:0] r;
        cycle = cycle + 1;
        if (!reset) begin
            acc           = in_valid && in_ready;
            accepted_last = acc;
            if (acc) begin
                if (model_credits == 0) flow_error("instruction accepted with no credit left");
                exp_q.push_back(decode_ref(in, exe_fwd, mem_fwd, wb_fwd));
                accepted++;
                model_credits--;
            end
            if (credit_return) model_credits++;
            // Write lands after this edge's reads
            if (wb_fwd.valid && wb_fwd.rd != '0) model_regs[wb_fwd.rd] = wb_fwd.data;

            r = $random(seed);
            if (accepted >= NUM_INSTS) begin
                in_valid <= 1'b0;
            end else if (acc || !in_valid) begin
                nxt.pc      = random_word();
                nxt.pc[1:0] = 2'b00;
                nxt.ir      = random_inst();
                in_valid    <= hold_credits || (r[2:0] != 3'b000);
                in          <= nxt;
            end
            exe_fwd <= random_fwd();
            mem_fwd <= random_fwd();
            wb_fwd  <= random_fwd();
            if (!hold_credits && ret_due.size() > 0 && ret_due[0] <= cycle) begin
                void'(ret_due.pop_front());
                credit_return <= 1'b1;
            end else begin
                credit_return <= 1'b0;
            end
        end
    end

    // Scoreboard on the stable half of the cycle
    always @(negedge clk) begin
        exe_bundle_t exp_b;
        logic [31:0] r;
        if (!reset) begin
            if (out_valid !== accepted_last)
                value_error("out_valid", xlen_t'(accepted_last), xlen_t'(out_valid));
            if (in_ready !== (model_credits != 0))
                value_error("in_ready", xlen_t'(model_credits != 0), xlen_t'(in_ready));
            if (out_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    flow_error("bundle on out with no accepted instruction pending");
                end else begin
                    exp_b = exp_q.pop_front();
                    compare_bundle(out, exp_b);
                    received++;
                    // Consumer frees its slot a few cycles later
                    r = $random(seed);
                    ret_due.push_back(cycle + 1 + int'(r[2:0]));
                end
            end
        end
    end

    initial begin
        seed          = 79;
        cycle         = 0;
        accepted      = 0;
        received      = 0;
        model_credits = `DE_CREDITS;
        value_errs    = 0;
        flow_errs     = 0;
        hold_credits  = 1'b1;
        accepted_last = 1'b0;
        for (int i = 0; i < `NUM_REGS; i++) model_regs[i] = '0;
        reset         <= 1'b1;
        in_valid      <= 1'b0;
        in            <= '0;
        exe_fwd       <= '0;
        mem_fwd       <= '0;
        wb_fwd        <= '0;
        credit_return <= 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (out_valid !== 1'b0) value_error("out_valid", '0, xlen_t'(out_valid));
        if (in_ready !== 1'b1) value_error("in_ready", 64'd1, xlen_t'(in_ready));

        // No credits come back until the stage has filled the queue
        while (in_ready === 1'b1 && cycle < CYCLE_LIMIT) @(negedge clk);
        if (accepted != `DE_CREDITS)
            value_error("accepted count", xlen_t'(`DE_CREDITS), xlen_t'(accepted));
        repeat (3) @(negedge clk);
        if (in_ready !== 1'b0) flow_error("in_ready rose with no credit returned");
        hold_credits = 1'b0;

        while (!(received == NUM_INSTS && model_credits == `DE_CREDITS) && cycle < CYCLE_LIMIT)
            @(negedge clk);
        timed_out = (cycle >= CYCLE_LIMIT);
        // Last scoreboard pass at this falling edge completes first
        @(posedge clk);
        if (timed_out) $display("Timeout after %0d cycles, run stopped", cycle);
        $display("Errors: %0d value, %0d flow; %0d of %0d bundles checked",
                 value_errs, flow_errs, received, NUM_INSTS);
        if (!timed_out && value_errs == 0 && flow_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
